// File: common/apb_defs.svh
`ifndef APB_DEFS_SVH
`define APB_DEFS_SVH

// bus widths
`define APB_ADDR_W 32
`define APB_DATA_W 32
`define APB_STRB_W (`APB_DATA_W / 8)
`define APB_PROT_W 3

// extra requester stall cycles per downstream wait cycle
`define APB_DELAY_MUL 9
// fraction bits kept in the delay counter
`define APB_DELAY_SHIFT 2

// address map, each region is 4 KB
`define REG_BASE    32'h0000_0000
`define SRAM_BASE   32'h0000_1000
`define REGION_MASK 32'hFFFF_F000

// scratch memory size in words
`define SRAM_DEPTH 64

`endif

// File: common/apb_if.sv
`include "apb_defs.svh"

interface apb_if;

    logic [`APB_ADDR_W-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic [`APB_PROT_W-1:0] pprot;
    logic                   pwrite;
    logic [`APB_DATA_W-1:0] pwdata;
    logic [`APB_STRB_W-1:0] pstrb;
    logic                   pready;
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pslverr;

    modport requester (
        output paddr, psel, penable, pprot, pwrite, pwdata, pstrb,
        input  pready, prdata, pslverr
    );

    modport completer (
        input  paddr, psel, penable, pprot, pwrite, pwdata, pstrb,
        output pready, prdata, pslverr
    );

endinterface

// File: common/apb_pkg.sv
`include "apb_defs.svh"

package apb_pkg;

    // downstream target picked by the address decode
    typedef enum logic [1:0] {
        TGT_REG,
        TGT_SRAM,
        TGT_NONE
    } target_e;

    // completion data returned to the requester
    typedef struct packed {
        logic [`APB_DATA_W-1:0] prdata;
        logic                   pslverr;
    } apb_resp_t;

endpackage

// File: design/apb_delayer.sv
`include "apb_defs.svh"

module apb_delayer (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`APB_ADDR_W-1:0] in_paddr,
    input  logic                   in_psel,
    input  logic                   in_penable,
    input  logic [`APB_PROT_W-1:0] in_pprot,
    input  logic                   in_pwrite,
    input  logic [`APB_DATA_W-1:0] in_pwdata,
    input  logic [`APB_STRB_W-1:0] in_pstrb,
    output logic                   in_pready,
    output logic [`APB_DATA_W-1:0] in_prdata,
    output logic                   in_pslverr,
    apb_if.requester               out
);

    localparam int CNT_W = 16;
    localparam logic [CNT_W-1:0] STEP = CNT_W'(`APB_DELAY_MUL << `APB_DELAY_SHIFT);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACTIVE,
        ST_DELAY
    } state_e;

    state_e             state;
    logic [CNT_W-1:0]   delay_cnt;
    apb_pkg::apb_resp_t held;
    logic               setup;
    logic               release_now;

    assign setup       = in_psel & ~in_penable;
    assign release_now = (state == ST_DELAY) && (delay_cnt == '0);

    // request goes straight down, psel is held off once the target has answered
    assign out.paddr   = in_paddr;
    assign out.psel    = in_psel & (state != ST_DELAY) & ~in_pready;
    assign out.penable = in_penable;
    assign out.pprot   = in_pprot;
    assign out.pwrite  = in_pwrite;
    assign out.pwdata  = in_pwdata;
    assign out.pstrb   = in_pstrb;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:   if (setup) state <= ST_ACTIVE;
                ST_ACTIVE: if (out.pready) state <= ST_DELAY;
                ST_DELAY:  if (delay_cnt == '0) state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // fixed point accumulate while waiting, drop the fraction at completion
    always_ff @(posedge clock) begin
        if (reset) begin
            delay_cnt <= '0;
        end else if (state == ST_ACTIVE) begin
            if (out.pready) begin
                delay_cnt <= delay_cnt >> `APB_DELAY_SHIFT;
            end else begin
                delay_cnt <= delay_cnt + STEP;
            end
        end else if ((state == ST_DELAY) && (delay_cnt != '0)) begin
            delay_cnt <= delay_cnt - CNT_W'(1);
        end
    end

    always_ff @(posedge clock) begin
        if ((state == ST_ACTIVE) && out.pready) begin
            held <= '{prdata: out.prdata, pslverr: out.pslverr};
        end
    end

    // one cycle completion, data is zero outside of it
    always_ff @(posedge clock) begin
        if (reset) begin
            in_pready  <= 1'b0;
            in_prdata  <= '0;
            in_pslverr <= 1'b0;
        end else if (release_now) begin
            in_pready  <= 1'b1;
            in_prdata  <= held.prdata;
            in_pslverr <= held.pslverr;
        end else begin
            in_pready  <= 1'b0;
            in_prdata  <= '0;
            in_pslverr <= 1'b0;
        end
    end

endmodule

// File: design/apb_reg_bank.sv
`include "apb_defs.svh"

module apb_reg_bank (
    input  logic       clock,
    input  logic       reset,
    apb_if.completer   bus,
    output logic [3:0] sram_wait
);

    localparam logic [`APB_DATA_W-1:0] ID_VALUE = 32'h4150_4231;

    // 0 wait control, 1 and 2 scratch, 3 is the fixed id
    logic [`APB_DATA_W-1:0] wait_ctrl;
    logic [`APB_DATA_W-1:0] scratch_a;
    logic [`APB_DATA_W-1:0] scratch_b;
    logic [1:0]             index;
    logic                   access;
    logic                   id_hit;

    assign index  = bus.paddr[3:2];
    assign access = bus.psel & bus.penable;
    assign id_hit = (index == 2'd3);

    always_ff @(posedge clock) begin
        if (reset) begin
            wait_ctrl <= '0;
            scratch_a <= '0;
            scratch_b <= '0;
        end else if (access && bus.pwrite) begin
            for (int b = 0; b < `APB_STRB_W; b++) begin
                if (bus.pstrb[b]) begin
                    case (index)
                        2'd0:    wait_ctrl[8*b +: 8] <= bus.pwdata[8*b +: 8];
                        2'd1:    scratch_a[8*b +: 8] <= bus.pwdata[8*b +: 8];
                        2'd2:    scratch_b[8*b +: 8] <= bus.pwdata[8*b +: 8];
                        default: ;
                    endcase
                end
            end
        end
    end

    always_comb begin
        case (index)
            2'd0:    bus.prdata = wait_ctrl;
            2'd1:    bus.prdata = scratch_a;
            2'd2:    bus.prdata = scratch_b;
            default: bus.prdata = ID_VALUE;
        endcase
    end

    // zero wait state
    assign bus.pready  = 1'b1;
    assign bus.pslverr = access & bus.pwrite & id_hit;

    assign sram_wait = wait_ctrl[3:0];

endmodule

// File: design/apb_sram_target.sv
`include "apb_defs.svh"

module apb_sram_target (
    input  logic       clock,
    input  logic       reset,
    apb_if.completer   bus,
    input  logic [3:0] sram_wait
);

    localparam int IDX_W = $clog2(`SRAM_DEPTH);

    logic [`APB_DATA_W-1:0] mem [0:`SRAM_DEPTH-1];
    logic [IDX_W-1:0]       index;
    logic [3:0]             wait_cnt;
    logic                   setup;
    logic                   access;

    assign index  = bus.paddr[IDX_W+1:2];
    assign setup  = bus.psel & ~bus.penable;
    assign access = bus.psel & bus.penable;

    // wait states are taken at setup, a later change does not affect this access
    always_ff @(posedge clock) begin
        if (reset) begin
            wait_cnt <= 4'd0;
        end else if (setup) begin
            wait_cnt <= sram_wait;
        end else if (access && (wait_cnt != 4'd0)) begin
            wait_cnt <= wait_cnt - 4'd1;
        end
    end

    assign bus.pready = access & (wait_cnt == 4'd0);

    always_ff @(posedge clock) begin
        if (bus.pready && bus.pwrite) begin
            for (int b = 0; b < `APB_STRB_W; b++) begin
                if (bus.pstrb[b]) begin
                    mem[index][8*b +: 8] <= bus.pwdata[8*b +: 8];
                end
            end
        end
    end

    assign bus.prdata  = mem[index];
    assign bus.pslverr = 1'b0;

endmodule

// File: design/apb_target_router.sv
`include "apb_defs.svh"

module apb_target_router (
    input  logic     clock,
    input  logic     reset,
    apb_if.completer up,
    apb_if.requester reg_side,
    apb_if.requester sram_side
);

    apb_pkg::target_e   target;
    apb_pkg::apb_resp_t resp;
    logic               resp_ready;
    logic               err_ready;

    always_comb begin
        if ((up.paddr & `REGION_MASK) == `REG_BASE) begin
            target = apb_pkg::TGT_REG;
        end else if ((up.paddr & `REGION_MASK) == `SRAM_BASE) begin
            target = apb_pkg::TGT_SRAM;
        end else begin
            target = apb_pkg::TGT_NONE;
        end
    end

    assign reg_side.paddr   = up.paddr;
    assign reg_side.psel    = up.psel & (target == apb_pkg::TGT_REG);
    assign reg_side.penable = up.penable & (target == apb_pkg::TGT_REG);
    assign reg_side.pprot   = up.pprot;
    assign reg_side.pwrite  = up.pwrite;
    assign reg_side.pwdata  = up.pwdata;
    assign reg_side.pstrb   = up.pstrb;

    assign sram_side.paddr   = up.paddr;
    assign sram_side.psel    = up.psel & (target == apb_pkg::TGT_SRAM);
    assign sram_side.penable = up.penable & (target == apb_pkg::TGT_SRAM);
    assign sram_side.pprot   = up.pprot;
    assign sram_side.pwrite  = up.pwrite;
    assign sram_side.pwdata  = up.pwdata;
    assign sram_side.pstrb   = up.pstrb;

    // unmapped access answers in its first access cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            err_ready <= 1'b0;
        end else begin
            err_ready <= up.psel & ~up.penable & (target == apb_pkg::TGT_NONE);
        end
    end

    always_comb begin
        case (target)
            apb_pkg::TGT_REG: begin
                resp_ready = reg_side.pready;
                resp       = '{prdata: reg_side.prdata, pslverr: reg_side.pslverr};
            end
            apb_pkg::TGT_SRAM: begin
                resp_ready = sram_side.pready;
                resp       = '{prdata: sram_side.prdata, pslverr: sram_side.pslverr};
            end
            default: begin
                resp_ready = err_ready;
                resp       = '{prdata: '0, pslverr: err_ready};
            end
        endcase
    end

    assign up.pready  = resp_ready;
    assign up.prdata  = resp.prdata;
    assign up.pslverr = resp.pslverr;

endmodule

// File: design/apb_timing_model.sv
`include "apb_defs.svh"

module apb_timing_model (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`APB_ADDR_W-1:0] in_paddr,
    input  logic                   in_psel,
    input  logic                   in_penable,
    input  logic [`APB_PROT_W-1:0] in_pprot,
    input  logic                   in_pwrite,
    input  logic [`APB_DATA_W-1:0] in_pwdata,
    input  logic [`APB_STRB_W-1:0] in_pstrb,
    output logic                   in_pready,
    output logic [`APB_DATA_W-1:0] in_prdata,
    output logic                   in_pslverr
);

    apb_if dly_bus ();
    apb_if reg_bus ();
    apb_if sram_bus ();

    logic [3:0] sram_wait;

    apb_delayer u_apb_delayer (
        .clock      (clock),
        .reset      (reset),
        .in_paddr   (in_paddr),
        .in_psel    (in_psel),
        .in_penable (in_penable),
        .in_pprot   (in_pprot),
        .in_pwrite  (in_pwrite),
        .in_pwdata  (in_pwdata),
        .in_pstrb   (in_pstrb),
        .in_pready  (in_pready),
        .in_prdata  (in_prdata),
        .in_pslverr (in_pslverr),
        .out        (dly_bus.requester)
    );

    apb_target_router u_apb_target_router (
        .clock     (clock),
        .reset     (reset),
        .up        (dly_bus.completer),
        .reg_side  (reg_bus.requester),
        .sram_side (sram_bus.requester)
    );

    apb_reg_bank u_apb_reg_bank (
        .clock     (clock),
        .reset     (reset),
        .bus       (reg_bus.completer),
        .sram_wait (sram_wait)
    );

    apb_sram_target u_apb_sram_target (
        .clock     (clock),
        .reset     (reset),
        .bus       (sram_bus.completer),
        .sram_wait (sram_wait)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_apb_timing_model -f sim.f -o tb_apb_timing_model_sim

./obj_dir/tb_apb_timing_model_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: sim.f
+incdir+common
common/apb_pkg.sv
common/apb_if.sv
design/apb_delayer.sv
design/apb_target_router.sv
design/apb_reg_bank.sv
design/apb_sram_target.sv
design/apb_timing_model.sv
testbench/tb_apb_model.sv
testbench/tb_apb_timing_model.sv

// File: testbench/tb_apb_model.sv
`include "apb_defs.svh"

package tb_apb_model;

    localparam logic [31:0] ID_VALUE   = 32'h4150_4231;
    localparam int          SRAM_IDX_W = $clog2(`SRAM_DEPTH);

    // registers 0 to 2, register 3 is the constant id
    logic [31:0] regs [0:2];
    logic [31:0] mem  [0:`SRAM_DEPTH-1];

    function automatic apb_pkg::target_e region_of(input logic [31:0] addr);
        if ((addr & `REGION_MASK) == `REG_BASE) begin
            return apb_pkg::TGT_REG;
        end else if ((addr & `REGION_MASK) == `SRAM_BASE) begin
            return apb_pkg::TGT_SRAM;
        end
        return apb_pkg::TGT_NONE;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic void clear_regs();
        for (int i = 0; i < 3; i++) begin
            regs[i] = '0;
        end
    endfunction

    // every downstream wait cycle costs APB_DELAY_MUL more cycles upstream
    function automatic int min_latency(input logic [31:0] addr);
        if (region_of(addr) == apb_pkg::TGT_SRAM) begin
            return `APB_DELAY_MUL * int'(regs[0][3:0]) + 2;
        end
        return 3;
    endfunction

    function automatic void access(input  logic [31:0] addr,
                                   input  logic        write,
                                   input  logic [31:0] wdata,
                                   input  logic [3:0]  strb,
                                   output logic [31:0] rdata,
                                   output logic        err);
        logic [1:0]            index;
        logic [SRAM_IDX_W-1:0] word;
        index = addr[3:2];
        word  = addr[SRAM_IDX_W+1:2];
        rdata = '0;
        err   = 1'b0;
        case (region_of(addr))
            apb_pkg::TGT_REG: begin
                if (index == 2'd3) begin
                    rdata = ID_VALUE;
                    err   = write;
                end else if (write) begin
                    regs[index] = merge_bytes(regs[index], wdata, strb);
                end else begin
                    rdata = regs[index];
                end
            end
            apb_pkg::TGT_SRAM: begin
                if (write) begin
                    mem[word] = merge_bytes(mem[word], wdata, strb);
                end else begin
                    rdata = mem[word];
                end
            end
            default: begin
                err = 1'b1;
            end
        endcase
    endfunction

endpackage

// File: testbench/tb_apb_timing_model.sv
`include "apb_defs.svh"

module tb_apb_timing_model;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD    = 10;
    localparam int NUM_DIRECTED  = 90;
    localparam int NUM_RANDOM    = 400;
    // 15 wait states scaled by the delayer, plus setup and idle
    localparam int ACCESS_CYCLES = 16 * 10 + 5;
    localparam int WATCHDOG_NS   = (NUM_DIRECTED + NUM_RANDOM) * ACCESS_CYCLES * CLK_PERIOD;

    logic                   clock;
    logic                   reset;
    logic [`APB_ADDR_W-1:0] in_paddr;
    logic                   in_psel;
    logic                   in_penable;
    logic [`APB_PROT_W-1:0] in_pprot;
    logic                   in_pwrite;
    logic [`APB_DATA_W-1:0] in_pwdata;
    logic [`APB_STRB_W-1:0] in_pstrb;
    logic                   in_pready;
    logic [`APB_DATA_W-1:0] in_prdata;
    logic                   in_pslverr;
    logic [31:0]            rng_state = 32'd42238;

    apb_timing_model u_apb_timing_model (
        .clock      (clock),
        .reset      (reset),
        .in_paddr   (in_paddr),
        .in_psel    (in_psel),
        .in_penable (in_penable),
        .in_pprot   (in_pprot),
        .in_pwrite  (in_pwrite),
        .in_pwdata  (in_pwdata),
        .in_pstrb   (in_pstrb),
        .in_pready  (in_pready),
        .in_prdata  (in_prdata),
        .in_pslverr (in_pslverr)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0d ns %s: got 0x%08h, expected 0x%08h",
                     $time, what, got, expected);
            abort_run();
        end
    endtask

    // one APB transfer that counts cycles from the setup edge to in_pready
    task automatic bus_transfer(input  logic [31:0] addr,
                                input  logic        write,
                                input  logic [31:0] wdata,
                                input  logic [3:0]  strb,
                                output logic [31:0] rdata,
                                output logic        err,
                                output int          cycles);
        @(posedge clock);
        #1;
        in_paddr   = addr;
        in_psel    = 1'b1;
        in_penable = 1'b0;
        in_pprot   = {write, addr[3:2]};
        in_pwrite  = write;
        in_pwdata  = wdata;
        in_pstrb   = strb;
        @(posedge clock);
        #1;
        in_penable = 1'b1;
        cycles     = 1;
        @(negedge clock);
        while (!in_pready) begin
            cycles++;
            if (cycles > ACCESS_CYCLES) begin
                $display("no in_pready from the DUT within %0d cycles at address %h",
                         ACCESS_CYCLES, addr);
                abort_run();
            end
            @(negedge clock);
        end
        rdata = in_prdata;
        err   = in_pslverr;
        @(posedge clock);
        #1;
        in_psel    = 1'b0;
        in_penable = 1'b0;
        // completion lasts a single cycle
        @(negedge clock);
        check_value("in_pready after completion", {31'd0, in_pready}, 32'd0);
        check_value("in_pslverr while idle", {31'd0, in_pslverr}, 32'd0);
    endtask

    task automatic checked_access(input logic [31:0] addr, input logic write,
                                  input logic [31:0] wdata, input logic [3:0] strb);
        logic [31:0] got_data;
        logic        got_err;
        logic [31:0] exp_data;
        logic        exp_err;
        logic        sram_hit;
        int          cycles;
        int          lat_min;
        lat_min  = tb_apb_model::min_latency(addr);
        sram_hit = (tb_apb_model::region_of(addr) == apb_pkg::TGT_SRAM);
        bus_transfer(addr, write, wdata, strb, got_data, got_err, cycles);
        tb_apb_model::access(addr, write, wdata, strb, exp_data, exp_err);
        check_value($sformatf("pslverr at %h", addr), {31'd0, got_err}, {31'd0, exp_err});
        if (!write && !exp_err) begin
            check_value($sformatf("read data at %h", addr), got_data, exp_data);
        end
        if (sram_hit) begin
            check_value($sformatf("sram latency %0d below %0d", cycles, lat_min),
                        (cycles >= lat_min) ? 32'd1 : 32'd0, 32'd1);
        end else begin
            check_value($sformatf("latency at %h", addr), 32'(cycles), 32'(lat_min));
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("simulation timed out after %0d ns", WATCHDOG_NS);
        abort_run();
    end

    initial begin
        logic [31:0] r_ctl;
        logic [31:0] r_addr;
        logic [31:0] r_data;
        logic [31:0] addr;
        reset      = 1'b1;
        in_paddr   = '0;
        in_psel    = 1'b0;
        in_penable = 1'b0;
        in_pprot   = '0;
        in_pwrite  = 1'b0;
        in_pwdata  = '0;
        in_pstrb   = '0;
        repeat (3) begin
            @(posedge clock);
            #1;
            check_value("in_pready in reset", {31'd0, in_pready}, 32'd0);
            check_value("in_pslverr in reset", {31'd0, in_pslverr}, 32'd0);
            check_value("in_prdata in reset", in_prdata, 32'd0);
        end
        reset = 1'b0;
        tb_apb_model::clear_regs();

        for (int i = 0; i < 4; i++) begin
            checked_access(`REG_BASE | 32'(i * 4), 1'b0, '0, 4'h0);
        end
        checked_access(`REG_BASE | 32'h4, 1'b1, 32'h1122_3344, 4'hF);
        checked_access(`REG_BASE | 32'h4, 1'b1, 32'hAABB_CCDD, 4'b0101);
        checked_access(`REG_BASE | 32'h4, 1'b0, '0, 4'h0);
        checked_access(`REG_BASE | 32'h8, 1'b1, 32'hDEAD_BEEF, 4'b1100);
        checked_access(`REG_BASE | 32'h8, 1'b0, '0, 4'h0);
        checked_access(`REG_BASE | 32'h0, 1'b1, 32'hFFFF_FFF0, 4'b0010);
        checked_access(`REG_BASE | 32'h0, 1'b0, '0, 4'h0);

        // id writes and unmapped accesses fail and leave state alone
        checked_access(`REG_BASE | 32'hC, 1'b1, 32'h0, 4'hF);
        checked_access(`REG_BASE | 32'hC, 1'b0, '0, 4'h0);
        checked_access(32'h0000_3004, 1'b1, 32'h5555_AAAA, 4'hF);
        checked_access(32'h8000_1000, 1'b0, '0, 4'h0);
        checked_access(`REG_BASE | 32'h4, 1'b0, '0, 4'h0);

        for (int w = 0; w < `SRAM_DEPTH; w++) begin
            addr = `SRAM_BASE | 32'(w * 4);
            checked_access(addr, 1'b1, addr ^ {addr[15:0], addr[31:16]} ^ 32'hC3A5_0F96, 4'hF);
        end

        checked_access(`REG_BASE | 32'h0, 1'b1, 32'h0000_0003, 4'b0001);
        checked_access(`SRAM_BASE | 32'h10, 1'b0, '0, 4'h0);
        checked_access(`SRAM_BASE | 32'h10, 1'b1, 32'h0BAD_F00D, 4'b0110);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            r_ctl  = xorshift();
            r_addr = xorshift();
            r_data = xorshift();
            case (r_ctl[1:0])
                2'd0:    addr = `REG_BASE | {28'd0, r_addr[1:0], 2'b00};
                2'd3:    addr = (r_addr & 32'hFFFF_E000) | 32'h0000_2000;
                default: addr = `SRAM_BASE | {24'd0, r_addr[5:0], 2'b00};
            endcase
            checked_access(addr, r_ctl[2], r_data, r_ctl[6:3]);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
